// ==== build.f ====
design/fetch_pkg.sv
design/pc_gen_stage.sv
design/inst_fetch_stage.sv
design/pre_decode_stage.sv
design/fetch_top.sv
test/fetch_checker.sv
test/fetch_tb.sv

// ==== Makefile ====
# Verilator build for the fetch front end

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= test passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass message shows up on a line of its own
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_tb
    import fetch_pkg::*;
;

    localparam addr_t RESET_PC    = 32'h1c00_0000;
    localparam int    BTB_ENTRIES = 16;
    localparam int    ROM_DEPTH   = 256;
    localparam int    N_PACKETS   = 2000;
    localparam int    SEED        = 32'hd53be3fb;

    localparam opcode_t BRANCH_OPS [9] = '{
        op_jirl, op_b, op_bl, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu
    };

    logic       clk;
    logic       rst_n;
    logic       prog_en;
    addr_t      prog_addr;
    inst_t      prog_data;
    logic       out_valid;
    logic       out_ready;
    fetch_out_t out;
    int         seed;

    string behavior_name [6] = '{
        "reset and first pc", "rom contents", "branch type",
        "static next pc", "pc continuity", "stall stability"
    };

    fetch_top #(
        .RESET_PC    (RESET_PC),
        .BTB_ENTRIES (BTB_ENTRIES),
        .ROM_DEPTH   (ROM_DEPTH)
    ) u_fetch_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_en   (prog_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out)
    );

    fetch_checker #(
        .RESET_PC  (RESET_PC),
        .ROM_DEPTH (ROM_DEPTH)
    ) u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_en   (prog_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_behavior(input int b);
        $display("behavior %0d (%s): %0d checks, %0d errors", b + 1, behavior_name[b],
                 u_checker.check_cnt[b], u_checker.err_cnt[b]);
    endtask

    // roughly a third branches, filler kept out of the branch opcodes
    task automatic load_rom;
        inst_t word;
        int    sel;
        for (int i = 0; i < ROM_DEPTH; i++) begin
            word = $random(seed);
            sel  = {$random(seed)} % 3;
            if (sel == 0) begin
                word[31:26] = BRANCH_OPS[{$random(seed)} % 9];
            end else if (word[31:26] >= op_jirl && word[31:26] <= op_bgeu) begin
                word[31] = 1'b1;
            end
            @(posedge clk);
            prog_en   <= 1'b1;
            prog_addr <= RESET_PC + addr_t'(i * 4);
            prog_data <= word;
        end
        @(posedge clk);
        prog_en <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int checks;
        int errors;
        rst_n     = 1'b0;
        prog_en   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        out_ready = 1'b0;
        seed      = SEED;
        checks    = 0;
        errors    = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        load_rom();
        while (u_checker.pkt_count < N_PACKETS) begin
            @(posedge clk);
            out_ready <= ({$random(seed)} % 4) != 0;
        end
        @(negedge clk);
        for (int b = 1; b < 6; b++) begin
            report_behavior(b);
        end
        for (int b = 0; b < 6; b++) begin
            checks += u_checker.check_cnt[b];
            errors += u_checker.err_cnt[b];
        end
        $display("summary: %0d packets, %0d checks, %0d errors",
                 u_checker.pkt_count, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // first packet closes the reset behavior
    initial begin
        wait (u_checker.pkt_count >= 1);
        @(negedge clk);
        report_behavior(0);
    end

    initial begin
        repeat (ROM_DEPTH + 4 * N_PACKETS) @(posedge clk);
        $display("timeout: only %0d of %0d packets delivered", u_checker.pkt_count,
                 N_PACKETS);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/fetch_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_checker
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC  = 32'h1c00_0000,
    parameter int    ROM_DEPTH = 256
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       prog_en,
    input  addr_t      prog_addr,
    input  inst_t      prog_data,
    input  logic       out_valid,
    input  logic       out_ready,
    input  fetch_out_t out
);

    inst_t      rom_model [ROM_DEPTH];
    int         pkt_count;
    int         check_cnt [6];
    int         err_cnt [6];
    logic       seen_load;
    logic       load_done;
    logic       have_prev;
    addr_t      prev_next;
    logic       held;
    fetch_out_t held_pkt;

    initial begin
        pkt_count = 0;
        for (int i = 0; i < 6; i++) begin
            check_cnt[i] = 0;
            err_cnt[i]   = 0;
        end
    end

    ////////////////////////////////////////////////////////////
    // reference rules
    ////////////////////////////////////////////////////////////
    function automatic int rom_index(input addr_t a);
        return int'((a >> 2) % ROM_DEPTH);
    endfunction

    function automatic br_type_e expected_type(input inst_t inst);
        case (inst[31:26])
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: return br_cond;
            op_b:    return br_cond;
            op_bl:   return br_call;
            op_jirl: return br_jirl;
            default: return br_none;
        endcase
    endfunction

    // b and bl use the 26-bit offset, the rest the 16-bit one
    function automatic addr_t static_target(input addr_t pc, input inst_t inst);
        logic [15:0] offs16;
        logic [25:0] offs26;
        offs16 = inst[25:10];
        offs26 = {inst[9:0], inst[25:10]};
        if (inst[31:26] == op_b || inst[31:26] == op_bl) begin
            return pc + {{4{offs26[25]}}, offs26, 2'b00};
        end
        return pc + {{14{offs16[15]}}, offs16, 2'b00};
    endfunction

    task automatic compare(input int b, input string name, input logic [31:0] got,
                           input logic [31:0] want);
        check_cnt[b]++;
        if (got !== want) begin
            err_cnt[b]++;
            $display("Fail %s: got %h, expected %h (pc %h)", name, got, want, out.pc);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // per-packet checks
    ////////////////////////////////////////////////////////////
    task automatic check_packet;
        br_type_e want_type;
        addr_t    target;
        addr_t    seq_pc;
        want_type = expected_type(out.inst);
        target    = static_target(out.pc, out.inst);
        seq_pc    = out.pc + 32'd4;
        if (!have_prev) begin
            compare(0, "out.pc", out.pc, RESET_PC);
        end else begin
            compare(4, "out.pc", out.pc, prev_next);
        end
        compare(1, "out.inst", out.inst, rom_model[rom_index(out.pc)]);
        compare(2, "out.br_type", 32'(out.br_type), 32'(want_type));
        if (out.inst[31:26] == op_b || out.inst[31:26] == op_bl) begin
            compare(3, "out.next_pc", out.next_pc, target);
        end else if (want_type == br_none) begin
            compare(3, "out.next_pc", out.next_pc, seq_pc);
        end else if (want_type == br_cond) begin
            check_cnt[4]++;
            if (out.next_pc !== seq_pc && out.next_pc !== target) begin
                err_cnt[4]++;
                $display("Fail out.next_pc: got %h, expected %h or %h",
                         out.next_pc, seq_pc, target);
            end
        end
        prev_next = out.next_pc;
        have_prev = 1'b1;
    endtask

    always @(posedge clk) begin
        if (prog_en) begin
            rom_model[rom_index(prog_addr)] = prog_data;
        end
        if (!rst_n) begin
            seen_load = 1'b0;
            load_done = 1'b0;
            have_prev = 1'b0;
            held      = 1'b0;
        end else begin
            if (!load_done) begin
                compare(0, "out_valid", 32'(out_valid), 32'd0);
            end
            seen_load = seen_load || prog_en;
            load_done = load_done || (seen_load && !prog_en);
            // a stalled packet must not change or vanish
            if (held) begin
                check_cnt[5]++;
                if (!out_valid) begin
                    err_cnt[5]++;
                    $display("output packet withdrawn while out_ready was low");
                end
                compare(5, "out.pc", out.pc, held_pkt.pc);
                compare(5, "out.inst", out.inst, held_pkt.inst);
                compare(5, "out.br_type", 32'(out.br_type), 32'(held_pkt.br_type));
                compare(5, "out.next_pc", out.next_pc, held_pkt.next_pc);
            end
            if (out_valid && out_ready) begin
                check_packet();
                pkt_count <= pkt_count + 1;
            end
            held     = out_valid && !out_ready;
            held_pkt = out;
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC    = 32'h1c00_0000,
    parameter int    BTB_ENTRIES = 16,
    parameter int    ROM_DEPTH   = 256
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       prog_en,
    input  addr_t      prog_addr,
    input  inst_t      prog_data,
    output logic       out_valid,
    input  logic       out_ready,
    output fetch_out_t out
);

    logic        req_valid;
    logic        req_ready;
    fetch_req_t  req;
    logic        inst_valid;
    logic        inst_ready;
    fetch_inst_t inst_pkt;
    redirect_t   redirect;

    ////////////////////////////////////////////////////////////
    // if1: pc and btb
    ////////////////////////////////////////////////////////////
    pc_gen_stage #(
        .RESET_PC    (RESET_PC),
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_pc_gen_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .hold      (prog_en),
        .redirect  (redirect),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req)
    );

    ////////////////////////////////////////////////////////////
    // if2: rom read
    ////////////////////////////////////////////////////////////
    inst_fetch_stage #(
        .ROM_DEPTH (ROM_DEPTH)
    ) u_inst_fetch_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .prog_en    (prog_en),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .flush      (redirect.valid),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst_pkt   (inst_pkt)
    );

    // if3: pre-decode and prediction check
    pre_decode_stage u_pre_decode_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst_pkt   (inst_pkt),
        .redirect   (redirect),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out        (out)
    );

endmodule

`default_nettype wire

// ==== design/pre_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module pre_decode_stage
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        inst_valid,
    output logic        inst_ready,
    input  fetch_inst_t inst_pkt,
    output redirect_t   redirect,
    output logic        out_valid,
    input  logic        out_ready,
    output fetch_out_t  out
);

    addr_t      pc;
    inst_t      inst;
    addr_t      pred_pc;
    opcode_t    opcode;
    br_type_e   dec_type;
    logic       is_cond;
    logic       is_b_bl;
    logic       is_jirl;
    addr_t      offset;
    addr_t      seq_pc;
    addr_t      static_target;
    logic       type_right;
    logic       target_right;
    logic       mispredict;
    addr_t      next_pc;
    logic       accept;
    logic       out_valid_q;
    fetch_out_t out_q;

    assign pc      = inst_pkt.req.pc;
    assign inst    = inst_pkt.inst;
    assign pred_pc = inst_pkt.req.pred_pc;
    assign opcode  = inst[31:26];

    ////////////////////////////////////////////////////////////
    // branch classification
    ////////////////////////////////////////////////////////////
    always_comb begin
        is_cond  = 1'b0;
        is_b_bl  = 1'b0;
        is_jirl  = 1'b0;
        dec_type = br_none;
        case (opcode)
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                is_cond  = 1'b1;
                dec_type = br_cond;
            end
            // b shares the conditional class
            op_b: begin
                is_b_bl  = 1'b1;
                dec_type = br_cond;
            end
            op_bl: begin
                is_b_bl  = 1'b1;
                dec_type = br_call;
            end
            op_jirl: begin
                is_jirl  = 1'b1;
                dec_type = br_jirl;
            end
            default: begin
                dec_type = br_none;
            end
        endcase
    end

    // offs16 in [25:10], offs26 split as {[9:0], [25:10]}
    always_comb begin
        if (is_cond || is_jirl) begin
            offset = {{14{inst[25]}}, inst[25:10], 2'b00};
        end else if (is_b_bl) begin
            offset = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end else begin
            offset = 32'd4;
        end
    end

    assign seq_pc        = pc + 32'd4;
    assign static_target = pc + offset;

    ////////////////////////////////////////////////////////////
    // prediction check
    ////////////////////////////////////////////////////////////
    assign type_right   = (dec_type == inst_pkt.req.pred_type);
    assign target_right = (static_target == pred_pc);

    // jirl target is unknown here, so its prediction stands
    always_comb begin
        if (!type_right) begin
            mispredict = 1'b1;
        end else if (is_b_bl) begin
            mispredict = !target_right;
        end else if ((pred_pc == seq_pc) || is_jirl) begin
            mispredict = 1'b0;
        end else begin
            mispredict = !target_right;
        end
    end

    // static guess for a rejected conditional: backward taken
    always_comb begin
        if (is_b_bl) begin
            next_pc = static_target;
        end else if (is_jirl) begin
            next_pc = pred_pc;
        end else if (!mispredict) begin
            next_pc = pred_pc;
        end else if (static_target < pc) begin
            next_pc = static_target;
        end else begin
            next_pc = seq_pc;
        end
    end

    ////////////////////////////////////////////////////////////
    // redirect and output register
    ////////////////////////////////////////////////////////////
    assign inst_ready = !out_valid_q || out_ready;
    assign accept     = inst_valid && inst_ready;

    always_comb begin
        redirect.valid   = accept && mispredict;
        redirect.pc      = pc;
        redirect.br_type = dec_type;
        redirect.target  = next_pc;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_q.pc      <= pc;
            out_q.inst    <= inst;
            out_q.br_type <= dec_type;
            out_q.next_pc <= next_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
        end else if (accept) begin
            out_valid_q <= 1'b1;
        end else if (out_ready) begin
            out_valid_q <= 1'b0;
        end
    end

    assign out_valid = out_valid_q;
    assign out       = out_q;

endmodule

`default_nettype wire

// ==== design/inst_fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_fetch_stage
    import fetch_pkg::*;
#(
    parameter int ROM_DEPTH = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        prog_en,
    input  addr_t       prog_addr,
    input  inst_t       prog_data,
    input  logic        req_valid,
    output logic        req_ready,
    input  fetch_req_t  req,
    input  logic        flush,
    output logic        inst_valid,
    input  logic        inst_ready,
    output fetch_inst_t inst_pkt
);

    localparam int ROM_W = $clog2(ROM_DEPTH);

    typedef logic [ROM_W-1:0] rom_idx_t;

    inst_t      rom [ROM_DEPTH];
    rom_idx_t   wr_idx;
    rom_idx_t   rd_idx;
    logic       req_fire;
    logic       valid_q;
    fetch_req_t req_q;
    inst_t      inst_q;

    ////////////////////////////////////////////////////////////
    // instruction rom
    ////////////////////////////////////////////////////////////
    // byte addresses, word index wraps at the rom size
    assign wr_idx = prog_addr[ROM_W+1:2];
    assign rd_idx = req.pc[ROM_W+1:2];

    always_ff @(posedge clk) begin
        if (prog_en) begin
            rom[wr_idx] <= prog_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // request and read word register
    ////////////////////////////////////////////////////////////
    // can take a new request while the held one leaves
    assign req_ready = !valid_q || inst_ready;
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_q  <= req;
            inst_q <= rom[rd_idx];
        end
    end

    // flush also kills a wrong-path request taken this cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (req_fire) begin
            valid_q <= 1'b1;
        end else if (inst_ready) begin
            valid_q <= 1'b0;
        end
    end

    assign inst_valid = valid_q;
    assign inst_pkt   = '{req: req_q, inst: inst_q};

endmodule

`default_nettype wire

// ==== design/pc_gen_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_gen_stage
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC    = 32'h1c00_0000,
    parameter int    BTB_ENTRIES = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       hold,
    input  redirect_t  redirect,
    output logic       req_valid,
    input  logic       req_ready,
    output fetch_req_t req
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = 30 - IDX_W;

    typedef logic [IDX_W-1:0] btb_idx_t;
    typedef logic [TAG_W-1:0] btb_tag_t;

    typedef struct packed {
        btb_tag_t tag;
        br_type_e br_type;
        addr_t    target;
    } btb_entry_t;

    addr_t pc_q;
    addr_t pc_next;
    logic  valid_q;

    logic [BTB_ENTRIES-1:0] btb_valid;
    btb_entry_t             btb_mem [BTB_ENTRIES];

    btb_idx_t   rd_idx;
    btb_tag_t   rd_tag;
    btb_entry_t rd_entry;
    logic       btb_hit;
    btb_idx_t   wr_idx;

    ////////////////////////////////////////////////////////////
    // btb lookup on the current pc
    ////////////////////////////////////////////////////////////
    assign rd_idx   = pc_q[IDX_W+1:2];
    assign rd_tag   = pc_q[31:IDX_W+2];
    assign rd_entry = btb_mem[rd_idx];
    assign btb_hit  = btb_valid[rd_idx] && (rd_entry.tag == rd_tag);

    // miss falls back to sequential fetch
    always_comb begin
        req.pc        = pc_q;
        req.pred_type = btb_hit ? rd_entry.br_type : br_none;
        req.pred_pc   = btb_hit ? rd_entry.target : pc_q + 32'd4;
    end

    assign req_valid = valid_q && !hold;

    ////////////////////////////////////////////////////////////
    // pc register
    ////////////////////////////////////////////////////////////
    // redirect wins over the prediction and drops the current request
    always_comb begin
        if (redirect.valid) begin
            pc_next = redirect.target;
        end else if (req_valid && req_ready) begin
            pc_next = req.pred_pc;
        end else begin
            pc_next = pc_q;
        end
    end

    // parked at the reset vector while the rom is loaded
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q    <= RESET_PC;
            valid_q <= 1'b0;
        end else if (hold) begin
            pc_q    <= RESET_PC;
            valid_q <= 1'b0;
        end else begin
            pc_q    <= pc_next;
            valid_q <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // btb update from the redirect
    ////////////////////////////////////////////////////////////
    assign wr_idx = redirect.pc[IDX_W+1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btb_valid <= '0;
        end else if (redirect.valid) begin
            btb_valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect.valid) begin
            btb_mem[wr_idx].tag     <= redirect.pc[31:IDX_W+2];
            btb_mem[wr_idx].br_type <= redirect.br_type;
            btb_mem[wr_idx].target  <= redirect.target;
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [5:0]  opcode_t;

    // branch class as seen by the predictor
    typedef enum logic [1:0] {
        br_none = 2'b00,
        // conditional branches and plain b
        br_cond = 2'b01,
        br_call = 2'b10,
        br_jirl = 2'b11
    } br_type_e;

    ////////////////////////////////////////////////////////////
    // major opcodes, inst[31:26]
    ////////////////////////////////////////////////////////////
    localparam opcode_t op_jirl = 6'h13;
    localparam opcode_t op_b    = 6'h14;
    localparam opcode_t op_bl   = 6'h15;
    localparam opcode_t op_beq  = 6'h16;
    localparam opcode_t op_bne  = 6'h17;
    localparam opcode_t op_blt  = 6'h18;
    localparam opcode_t op_bge  = 6'h19;
    localparam opcode_t op_bltu = 6'h1a;
    localparam opcode_t op_bgeu = 6'h1b;

    ////////////////////////////////////////////////////////////
    // stage payloads
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        addr_t    pc;
        br_type_e pred_type;
        addr_t    pred_pc;
    } fetch_req_t;

    typedef struct packed {
        fetch_req_t req;
        inst_t      inst;
    } fetch_inst_t;

    typedef struct packed {
        addr_t    pc;
        inst_t    inst;
        br_type_e br_type;
        addr_t    next_pc;
    } fetch_out_t;

    // flush toward the front, also trains the btb
    typedef struct packed {
        logic     valid;
        addr_t    pc;
        br_type_e br_type;
        addr_t    target;
    } redirect_t;

endpackage

`default_nettype wire
